// ==== src/softmax_cfg.svh ====
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// lanes per memory row
`define SOFTMAX_LANES 4

// fixed-point lane width
`define SOFTMAX_LANE_W 16

// row address width, 8 rows
`define SOFTMAX_ADDR_W 3

// result rows the consumer may hold at once
`define SOFTMAX_CREDITS 4

// accumulated total of all differences
`define SOFTMAX_SUM_W 24

`endif

// ==== src/softmax_pkg.sv ====
`include "softmax_cfg.svh"

package softmax_pkg;

  typedef logic signed [`SOFTMAX_LANE_W-1:0] lane_t;

  // lane 0 sits in the low bits
  typedef logic [`SOFTMAX_LANES*`SOFTMAX_LANE_W-1:0] row_t;

  // one extra bit so lane minus max cannot overflow
  typedef logic signed [`SOFTMAX_LANE_W:0] diff_t;
  typedef logic [`SOFTMAX_LANES*(`SOFTMAX_LANE_W+1)-1:0] diff_row_t;

  typedef logic signed [`SOFTMAX_SUM_W-1:0] sum_t;
  typedef logic [`SOFTMAX_ADDR_W-1:0] addr_t;

  typedef enum logic [2:0] {
    IDLE,
    MAX_PASS,
    WAIT_MAX,
    SUB_PASS,
    DRAIN
  } fetch_state_t;

endpackage

// ==== src/row_fetch.sv ====
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module row_fetch (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  softmax_pkg::addr_t start_addr,
  input  softmax_pkg::addr_t end_addr,
  input  logic               max_ready,
  input  logic               out_credit,
  input  logic               done,
  output softmax_pkg::addr_t mem_addr,
  output logic               mem_rd,
  output logic               busy,
  output logic               max_pass_valid,
  output logic               sub_pass_valid,
  output logic               row_first,
  output logic               row_last
);

  localparam int CREDIT_W = $clog2(`SOFTMAX_CREDITS + 1);

  softmax_pkg::fetch_state_t state;
  softmax_pkg::addr_t first_addr;
  softmax_pkg::addr_t last_addr;
  softmax_pkg::addr_t addr;
  logic pass1_first;
  logic [CREDIT_W-1:0] credits;
  logic at_last;
  logic empty_start;
  logic issue_max;
  logic issue_sub;
  logic issue_first;
  logic issue_last;

  assign at_last = (addr == last_addr);
  assign empty_start = (state == softmax_pkg::IDLE) && start && (end_addr <= start_addr);
  assign issue_max = (state == softmax_pkg::MAX_PASS);
  // pass 2 only reads while the consumer has room
  assign issue_sub = (state == softmax_pkg::SUB_PASS) && (credits != '0);
  assign mem_rd = issue_max | issue_sub;
  assign mem_addr = addr;
  assign busy = (state != softmax_pkg::IDLE);

  // pass 1 never tags one read as both first and last; a single row is read twice.
  // first and last together without a valid then marks an empty run
  always_comb begin
    issue_first = 1'b0;
    issue_last = 1'b0;
    case (state)
      softmax_pkg::IDLE: begin
        issue_first = empty_start;
        issue_last = empty_start;
      end
      softmax_pkg::MAX_PASS: begin
        issue_first = pass1_first;
        issue_last = at_last && !pass1_first;
      end
      softmax_pkg::SUB_PASS: begin
        issue_first = issue_sub && (addr == first_addr);
        issue_last = issue_sub && at_last;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= softmax_pkg::IDLE;
      addr <= '0;
      first_addr <= '0;
      last_addr <= '0;
      pass1_first <= 1'b0;
    end else begin
      case (state)
        softmax_pkg::IDLE: begin
          if (start) begin
            first_addr <= start_addr;
            last_addr <= end_addr - 1'b1;
            addr <= start_addr;
            pass1_first <= 1'b1;
            state <= empty_start ? softmax_pkg::DRAIN : softmax_pkg::MAX_PASS;
          end
        end
        softmax_pkg::MAX_PASS: begin
          pass1_first <= 1'b0;
          if (issue_last) begin
            addr <= first_addr;
            state <= softmax_pkg::WAIT_MAX;
          end else if (!at_last) begin
            addr <= addr + 1'b1;
          end
        end
        softmax_pkg::WAIT_MAX: begin
          if (max_ready) begin
            state <= softmax_pkg::SUB_PASS;
          end
        end
        softmax_pkg::SUB_PASS: begin
          if (issue_sub) begin
            if (at_last) begin
              state <= softmax_pkg::DRAIN;
            end else begin
              addr <= addr + 1'b1;
            end
          end
        end
        default: begin
          // the adder tail decides when the run is over
          if (done) begin
            state <= softmax_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // credits carry over between runs, rows still held from the last run count
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(`SOFTMAX_CREDITS);
    end else begin
      credits <= credits + CREDIT_W'(out_credit) - CREDIT_W'(issue_sub);
    end
  end

  // tags follow the read by one cycle to line up with mem_data
  always_ff @(posedge clk) begin
    if (reset) begin
      max_pass_valid <= 1'b0;
      sub_pass_valid <= 1'b0;
      row_first <= 1'b0;
      row_last <= 1'b0;
    end else begin
      max_pass_valid <= issue_max;
      sub_pass_valid <= issue_sub;
      row_first <= issue_first;
      row_last <= issue_last;
    end
  end

endmodule

// ==== src/max_tree.sv ====
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module max_tree (
  input  logic                clk,
  input  logic                reset,
  input  softmax_pkg::row_t   row,
  input  logic                max_pass_valid,
  input  logic                row_first,
  input  logic                row_last,
  output softmax_pkg::lane_t  max_val,
  output logic                max_ready
);

  localparam int LANES = `SOFTMAX_LANES;
  localparam int W = `SOFTMAX_LANE_W;

  softmax_pkg::lane_t lane [LANES];
  softmax_pkg::lane_t pair_max [LANES/2];
  softmax_pkg::lane_t row_max;

  function automatic softmax_pkg::lane_t max2(input softmax_pkg::lane_t a,
                                              input softmax_pkg::lane_t b);
    return (a > b) ? a : b;
  endfunction

  // two comparator levels, pairs then across pairs
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane[i] = row[i*W +: W];
    end
    for (int k = 0; k < LANES/2; k++) begin
      pair_max[k] = max2(lane[2*k], lane[2*k+1]);
    end
    row_max = pair_max[0];
    for (int k = 1; k < LANES/2; k++) begin
      row_max = max2(row_max, pair_max[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      max_val <= '0;
      max_ready <= 1'b0;
    end else begin
      // first row of the pass restarts the running max
      if (max_pass_valid) begin
        max_val <= row_first ? row_max : max2(row_max, max_val);
      end
      max_ready <= max_pass_valid && row_last;
    end
  end

endmodule

// ==== src/max_sub_stage.sv ====
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module max_sub_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  softmax_pkg::row_t      row,
  input  softmax_pkg::lane_t     max_val,
  input  logic                   sub_pass_valid,
  input  logic                   row_first,
  input  logic                   row_last,
  output softmax_pkg::diff_row_t out_row,
  output logic                   out_valid,
  output logic                   out_first,
  output logic                   out_last
);

  localparam int LANES = `SOFTMAX_LANES;
  localparam int W = `SOFTMAX_LANE_W;
  localparam int DW = `SOFTMAX_LANE_W + 1;

  softmax_pkg::lane_t lane [LANES];
  softmax_pkg::diff_t diff [LANES];
  softmax_pkg::diff_row_t next_row;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane[i] = row[i*W +: W];
      // sign-extend both sides before subtracting
      diff[i] = softmax_pkg::diff_t'(lane[i]) - softmax_pkg::diff_t'(max_val);
      next_row[i*DW +: DW] = diff[i];
    end
  end

  always_ff @(posedge clk) begin
    if (sub_pass_valid) begin
      out_row <= next_row;
    end
  end

  // pass 1 tags stop here, only the empty-run marker gets through without a valid
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_first <= 1'b0;
      out_last <= 1'b0;
    end else begin
      out_valid <= sub_pass_valid;
      out_first <= row_first && (sub_pass_valid || row_last);
      out_last <= row_last && (sub_pass_valid || row_first);
    end
  end

endmodule

// ==== src/sum_tree.sv ====
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module sum_tree (
  input  logic                   clk,
  input  logic                   reset,
  input  softmax_pkg::diff_row_t out_row,
  input  logic                   out_valid,
  input  logic                   out_first,
  input  logic                   out_last,
  output softmax_pkg::sum_t      sum,
  output logic                   done
);

  localparam int LANES = `SOFTMAX_LANES;
  localparam int DW = `SOFTMAX_LANE_W + 1;

  softmax_pkg::diff_t diff [LANES];
  softmax_pkg::sum_t pair_sum [LANES/2];
  softmax_pkg::sum_t pair_sum_q [LANES/2];
  softmax_pkg::sum_t row_total;
  logic valid_q;
  logic first_q;
  logic last_q;

  // level one, lane pairs
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      diff[i] = out_row[i*DW +: DW];
    end
    for (int k = 0; k < LANES/2; k++) begin
      pair_sum[k] = softmax_pkg::sum_t'(diff[2*k]) + softmax_pkg::sum_t'(diff[2*k+1]);
    end
  end

  always_ff @(posedge clk) begin
    if (out_valid) begin
      pair_sum_q <= pair_sum;
    end
  end

  // level two
  always_comb begin
    row_total = '0;
    for (int k = 0; k < LANES/2; k++) begin
      row_total = row_total + pair_sum_q[k];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
      last_q <= 1'b0;
      sum <= '0;
      done <= 1'b0;
    end else begin
      valid_q <= out_valid;
      first_q <= out_first;
      last_q <= out_last;
      // a first tag without a row clears the total for an empty run
      if (first_q) begin
        sum <= valid_q ? row_total : '0;
      end else if (valid_q) begin
        sum <= sum + row_total;
      end
      done <= last_q;
    end
  end

endmodule

// ==== src/softmax_top.sv ====
`timescale 1ns/1ps

module softmax_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  softmax_pkg::addr_t     start_addr,
  input  softmax_pkg::addr_t     end_addr,
  input  softmax_pkg::row_t      mem_data,
  output softmax_pkg::addr_t     mem_addr,
  output logic                   mem_rd,
  output softmax_pkg::diff_row_t out_row,
  output logic                   out_valid,
  input  logic                   out_credit,
  output softmax_pkg::sum_t      sum,
  output logic                   done,
  output logic                   busy
);

  logic max_ready;
  logic max_pass_valid;
  logic sub_pass_valid;
  logic row_first;
  logic row_last;
  logic out_first;
  logic out_last;
  softmax_pkg::lane_t max_val;

  row_fetch row_fetch_inst (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .start_addr     (start_addr),
    .end_addr       (end_addr),
    .max_ready      (max_ready),
    .out_credit     (out_credit),
    .done           (done),
    .mem_addr       (mem_addr),
    .mem_rd         (mem_rd),
    .busy           (busy),
    .max_pass_valid (max_pass_valid),
    .sub_pass_valid (sub_pass_valid),
    .row_first      (row_first),
    .row_last       (row_last)
  );

  max_tree max_tree_inst (
    .clk            (clk),
    .reset          (reset),
    .row            (mem_data),
    .max_pass_valid (max_pass_valid),
    .row_first      (row_first),
    .row_last       (row_last),
    .max_val        (max_val),
    .max_ready      (max_ready)
  );

  max_sub_stage max_sub_stage_inst (
    .clk            (clk),
    .reset          (reset),
    .row            (mem_data),
    .max_val        (max_val),
    .sub_pass_valid (sub_pass_valid),
    .row_first      (row_first),
    .row_last       (row_last),
    .out_row        (out_row),
    .out_valid      (out_valid),
    .out_first      (out_first),
    .out_last       (out_last)
  );

  sum_tree sum_tree_inst (
    .clk       (clk),
    .reset     (reset),
    .out_row   (out_row),
    .out_valid (out_valid),
    .out_first (out_first),
    .out_last  (out_last),
    .sum       (sum),
    .done      (done)
  );

endmodule

// ==== verification/softmax_tb.sv ====
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module softmax_tb;

  localparam int LANES = `SOFTMAX_LANES;
  localparam int W = `SOFTMAX_LANE_W;
  localparam int DW = `SOFTMAX_LANE_W + 1;
  localparam int ROWS = 1 << `SOFTMAX_ADDR_W;
  localparam int RUN_LIMIT = 600;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic start = 1'b0;
  softmax_pkg::addr_t start_addr = '0;
  softmax_pkg::addr_t end_addr = '0;
  softmax_pkg::row_t mem_data = '0;
  logic out_credit = 1'b0;
  softmax_pkg::addr_t mem_addr;
  logic mem_rd;
  softmax_pkg::diff_row_t out_row;
  logic out_valid;
  softmax_pkg::sum_t sum;
  logic done;
  logic busy;

  softmax_pkg::row_t mem [ROWS];
  softmax_pkg::diff_row_t expected_rows [$];
  softmax_pkg::sum_t expected_sum = '0;
  int expected_count = 0;
  int rows_seen = 0;
  int held = 0;
  int wait_cnt = 0;
  int delay_max = 6;
  logic idle_check = 1'b0;
  int check_count = 0;
  int value_errors = 0;
  int row_errors = 0;
  int credit_errors = 0;
  int timeouts = 0;

  softmax_top softmax_top_inst (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .mem_data   (mem_data),
    .mem_addr   (mem_addr),
    .mem_rd     (mem_rd),
    .out_row    (out_row),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .sum        (sum),
    .done       (done),
    .busy       (busy)
  );

  always #50 clk = ~clk;

  // synchronous memory returns data one cycle after mem_rd
  always @(posedge clk) begin
    if (mem_rd) begin
      mem_data <= mem[mem_addr];
    end
  end

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] expected);
    check_count++;
    if (got !== expected) begin
      value_errors++;
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  // lane minus range max for every row in [first, last) and the grand total
  function automatic void compute_reference(input softmax_pkg::row_t rows [ROWS],
                                            input int first, input int last,
                                            output softmax_pkg::lane_t max_lane,
                                            output softmax_pkg::diff_row_t diffs [ROWS],
                                            output softmax_pkg::sum_t total);
    softmax_pkg::lane_t lane;
    int max_int;
    int diff_val;
    int acc;
    max_int = -(1 << (W - 1));
    acc = 0;
    for (int a = 0; a < ROWS; a++) begin
      diffs[a] = '0;
    end
    for (int a = first; a < last; a++) begin
      for (int i = 0; i < LANES; i++) begin
        lane = rows[a][i*W +: W];
        if (int'(lane) > max_int) begin
          max_int = int'(lane);
        end
      end
    end
    for (int a = first; a < last; a++) begin
      for (int i = 0; i < LANES; i++) begin
        lane = rows[a][i*W +: W];
        diff_val = int'(lane) - max_int;
        diffs[a][i*DW +: DW] = diff_val[DW-1:0];
        acc += diff_val;
      end
    end
    max_lane = max_int[W-1:0];
    total = acc[`SOFTMAX_SUM_W-1:0];
  endfunction

  // consumer holds each row a random number of cycles, then returns its credit
  always @(posedge clk) begin
    int held_next;
    if (reset) begin
      held = 0;
      wait_cnt = 0;
      out_credit <= 1'b0;
    end else begin
      held_next = held + (out_valid ? 1 : 0);
      if (held_next > `SOFTMAX_CREDITS) begin
        $display("consumer holds %0d rows, more than the credits allow, at time %0t",
                 held_next, $time);
        credit_errors++;
      end
      out_credit <= 1'b0;
      if (held_next > 0) begin
        if (wait_cnt == 0) begin
          out_credit <= 1'b1;
          held_next--;
          wait_cnt = $urandom_range(delay_max, 0);
        end else begin
          wait_cnt--;
        end
      end
      held = held_next;
    end
  end

  always @(posedge clk) begin
    softmax_pkg::diff_row_t exp_row;
    if (!reset) begin
      if (idle_check) begin
        check_value("idle out_valid", 128'(out_valid), 128'(0));
        check_value("idle done", 128'(done), 128'(0));
        check_value("idle busy", 128'(busy), 128'(0));
        check_value("idle mem_rd", 128'(mem_rd), 128'(0));
        check_value("idle sum", 128'(sum), 128'(0));
      end
      if (out_valid) begin
        rows_seen++;
        if (expected_rows.size() == 0) begin
          $display("an output row arrived that no run expects, at time %0t", $time);
          row_errors++;
        end else begin
          exp_row = expected_rows.pop_front();
          check_value("output row", 128'(out_row), 128'(exp_row));
        end
      end
      if (done) begin
        check_value("sum at done", 128'(sum), 128'(expected_sum));
        check_value("rows at done", 128'(rows_seen), 128'(expected_count));
        rows_seen = 0;
      end
    end
  end

  task automatic finish_run();
    $display("checks %0d, value errors %0d, row errors %0d, credit errors %0d, timeouts %0d",
             check_count, value_errors, row_errors, credit_errors, timeouts);
    if (value_errors == 0 && row_errors == 0 && credit_errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic run_range(input int first, input int last);
    softmax_pkg::diff_row_t diffs [ROWS];
    softmax_pkg::lane_t max_lane;
    softmax_pkg::sum_t total;
    int cycles;
    // a run that never ended leaves the DUT in an unknown state
    if (timeouts != 0) begin
      return;
    end
    @(posedge clk);
    // busy has fallen together with the previous done
    check_value("busy before start", 128'(busy), 128'(0));
    compute_reference(mem, first, last, max_lane, diffs, total);
    for (int a = first; a < last; a++) begin
      expected_rows.push_back(diffs[a]);
    end
    expected_sum = total;
    expected_count = (last > first) ? last - first : 0;
    $display("run %0d to %0d, reference max %0d", first, last, max_lane);
    start_addr <= softmax_pkg::addr_t'(first);
    end_addr <= softmax_pkg::addr_t'(last);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      check_value("busy during run", 128'(busy), 128'(1));
    end while (done !== 1'b1 && cycles <= RUN_LIMIT);
    if (done !== 1'b1) begin
      $display("done did not arrive within %0d cycles of start", RUN_LIMIT);
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(21162));
    for (int a = 0; a < ROWS; a++) begin
      mem[a] = {$urandom, $urandom};
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    idle_check <= 1'b1;
    repeat (4) @(posedge clk);
    idle_check <= 1'b0;
    // 3-bit end address, so 0 to 7 is the widest range
    run_range(0, 7);
    run_range(2, 6);
    run_range(1, 7);
    // slow consumer keeps pass 2 stalled on credits
    delay_max <= 20;
    run_range(0, 7);
    run_range(3, 5);
    delay_max <= 6;
    run_range(5, 5);
    run_range(6, 2);
    run_range(6, 7);
    // extreme lanes give the largest differences
    mem[3][W-1:0] <= 16'h7fff;
    mem[4][2*W-1:W] <= 16'h8000;
    run_range(0, 7);
    repeat (10) @(posedge clk);
    finish_run();
  end

endmodule

// ==== sources.f ====
+incdir+src
src/softmax_pkg.sv
src/row_fetch.sv
src/max_tree.sv
src/max_sub_stage.sv
src/sum_tree.sv
src/softmax_top.sv
verification/softmax_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the softmax testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f sources.f --top-module softmax_tb -o softmax_sim \
  > build.log 2>&1 \
  && ./obj_dir/softmax_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"
exit 0
